/* rtl/simt_pkg.sv */
package simt_pkg;

	localparam int NUM_LANES = 8;

	typedef logic [2:0] warp_id_t;

	// Scoreboard slot that issued the instruction.
	typedef logic [1:0] scb_id_t;

	// One bit per lane.
	typedef logic [NUM_LANES-1:0] lane_mask_t;

	typedef logic [4:0] reg_addr_t;

	typedef logic [31:0] lane_word_t;

	// Lane 0 sits in the low bits.
	typedef logic [NUM_LANES*32-1:0] lane_vec_t;

endpackage

/* rtl/mem_pkg.sv */
package mem_pkg;

	// Word address inside one memory space.
	typedef logic [15:0] word_addr_t;

	// Eight lane addresses, lane 0 in the low bits.
	typedef logic [8*16-1:0] addr_vec_t;

	localparam int LINE_WORDS = 8;

	// Instruction offset, sign extended before the add.
	typedef logic signed [15:0] offset_t;

endpackage

/* rtl/mem_stage_if.sv */
interface mem_stage_if
	import simt_pkg::*;
	import mem_pkg::*;
();

	logic       valid;
	logic       is_read;
	logic       is_write;
	logic       shared;
	warp_id_t   warp;
	scb_id_t    scb;
	lane_mask_t mask;
	reg_addr_t  reg_addr;
	addr_vec_t  addr;
	lane_vec_t  data;
	// High when the slot may proceed.
	logic       hit;

	modport src (
		output valid, is_read, is_write, shared, warp, scb,
		output mask, reg_addr, addr, data, hit
	);

	modport dst (
		input valid, is_read, is_write, shared, warp, scb,
		input mask, reg_addr, addr, data, hit
	);

endinterface

/* rtl/mem_addr_gen.sv */
module mem_addr_gen
	import simt_pkg::*;
	import mem_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       instr_valid_i,
	input  logic       mem_read_i,
	input  logic       mem_write_i,
	input  logic       shared_i,
	input  warp_id_t   warp_id_i,
	input  scb_id_t    scb_id_i,
	input  lane_mask_t lane_mask_i,
	input  lane_vec_t  rs_data_i,
	input  lane_vec_t  rt_data_i,
	input  offset_t    offset_i,
	input  reg_addr_t  reg_addr_i,
	mem_stage_if.src   out_o
);

	localparam int aw = $bits(word_addr_t);
	localparam int dw = $bits(lane_word_t);

	logic       valid_q;
	logic       read_q;
	logic       write_q;
	logic       shared_q;
	warp_id_t   warp_q;
	scb_id_t    scb_q;
	lane_mask_t mask_q;
	lane_vec_t  rs_q;
	lane_vec_t  rt_q;
	offset_t    offset_q;
	reg_addr_t  reg_addr_q;
	lane_word_t ext_offset;
	addr_vec_t  eff_addr;

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			valid_q <= 1'b0;
			read_q  <= 1'b0;
			write_q <= 1'b0;
		end
		else
		begin
			valid_q <= instr_valid_i;
			read_q  <= instr_valid_i & mem_read_i;
			write_q <= instr_valid_i & mem_write_i;
		end
	end

	// Operand fields only load with a new instruction.
	always_ff @(posedge clk)
	begin
		if (instr_valid_i)
		begin
			shared_q   <= shared_i;
			warp_q     <= warp_id_i;
			scb_q      <= scb_id_i;
			mask_q     <= lane_mask_i;
			rs_q       <= rs_data_i;
			rt_q       <= rt_data_i;
			offset_q   <= offset_i;
			reg_addr_q <= reg_addr_i;
		end
	end

	assign ext_offset = {{(dw-$bits(offset_t)){offset_q[$bits(offset_t)-1]}}, offset_q};

	// Low half of rs plus offset gives the lane's word address.
	always_comb
	begin
		for (int l = 0; l < NUM_LANES; l++)
			eff_addr[l*aw +: aw] = word_addr_t'(rs_q[l*dw +: dw] + ext_offset);
	end

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			out_o.valid    <= 1'b0;
			out_o.is_read  <= 1'b0;
			out_o.is_write <= 1'b0;
		end
		else
		begin
			out_o.valid    <= valid_q;
			out_o.is_read  <= read_q;
			out_o.is_write <= write_q;
		end
	end

	always_ff @(posedge clk)
	begin
		out_o.shared   <= shared_q;
		out_o.warp     <= warp_q;
		out_o.scb      <= scb_q;
		out_o.mask     <= mask_q;
		out_o.reg_addr <= reg_addr_q;
		out_o.addr     <= eff_addr;
		out_o.data     <= rt_q;
		// Not checked yet, the tag stage decides.
		out_o.hit      <= 1'b1;
	end

endmodule

/* rtl/mem_cache_tag.sv */
module mem_cache_tag
	import simt_pkg::*;
	import mem_pkg::*;
#(
	parameter int mem_words   = 256,
	parameter int cache_lines = 4
)
(
	input  logic     clk,
	input  logic     rst,
	mem_stage_if.dst in_i,
	mem_stage_if.src out_o
);

	localparam int aw        = $bits(word_addr_t);
	localparam int addr_bits = $clog2(mem_words);
	localparam int off_bits  = $clog2(LINE_WORDS);
	localparam int idx_bits  = $clog2(cache_lines);
	localparam int tag_bits  = addr_bits - off_bits - idx_bits;

	typedef logic [idx_bits-1:0] line_idx_t;
	typedef logic [tag_bits-1:0] cache_tag_t;

	logic [cache_lines-1:0] line_valid_q;
	cache_tag_t             tag_q [cache_lines];
	line_idx_t              lane_idx [NUM_LANES];
	cache_tag_t             lane_tag [NUM_LANES];
	lane_mask_t             lane_hit;
	lane_mask_t             lane_miss;
	line_idx_t              fill_idx;
	cache_tag_t             fill_tag;
	logic                   all_hit;
	logic                   fill;

	// Bits above the memory depth are dropped, so addresses wrap.
	always_comb
	begin
		for (int l = 0; l < NUM_LANES; l++)
		begin
			lane_idx[l] = in_i.addr[l*aw + off_bits +: idx_bits];
			lane_tag[l] = in_i.addr[l*aw + off_bits + idx_bits +: tag_bits];
			lane_hit[l] = line_valid_q[lane_idx[l]] && (tag_q[lane_idx[l]] == lane_tag[l]);
		end
	end

	assign lane_miss = in_i.mask & ~lane_hit;
	assign all_hit   = in_i.shared || (lane_miss == '0);
	assign fill      = in_i.valid && !all_hit;

	// Lowest missing lane picks the line to install.
	always_comb
	begin
		fill_idx = lane_idx[0];
		fill_tag = lane_tag[0];
		for (int l = NUM_LANES - 1; l >= 0; l--)
		begin
			if (lane_miss[l])
			begin
				fill_idx = lane_idx[l];
				fill_tag = lane_tag[l];
			end
		end
	end

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
			line_valid_q <= '0;
		else if (fill)
			line_valid_q[fill_idx] <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (fill)
			tag_q[fill_idx] <= fill_tag;
	end

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			out_o.valid    <= 1'b0;
			out_o.is_read  <= 1'b0;
			out_o.is_write <= 1'b0;
		end
		else
		begin
			out_o.valid    <= in_i.valid;
			out_o.is_read  <= in_i.is_read;
			out_o.is_write <= in_i.is_write;
		end
	end

	always_ff @(posedge clk)
	begin
		out_o.shared   <= in_i.shared;
		out_o.warp     <= in_i.warp;
		out_o.scb      <= in_i.scb;
		out_o.mask     <= in_i.mask;
		out_o.reg_addr <= in_i.reg_addr;
		out_o.addr     <= in_i.addr;
		out_o.data     <= in_i.data;
		out_o.hit      <= all_hit;
	end

	// Operand collection never issues a combined read and write.
	rw_exclusive: assert property (@(posedge clk) disable iff (!rst)
		in_i.valid |-> !(in_i.is_read && in_i.is_write));

endmodule

/* rtl/mem_data_access.sv */
module mem_data_access
	import simt_pkg::*;
	import mem_pkg::*;
#(
	parameter int mem_words   = 256,
	parameter int shmem_words = 256
)
(
	input  logic       clk,
	input  logic       rst,
	input  logic       preload_we_i,
	input  word_addr_t preload_addr_i,
	input  lane_word_t preload_data_i,
	mem_stage_if.dst   in_i,
	mem_stage_if.src   out_o
);

	localparam int gaddr_bits = $clog2(mem_words);
	localparam int saddr_bits = $clog2(shmem_words);
	localparam int aw         = $bits(word_addr_t);
	localparam int dw         = $bits(lane_word_t);

	lane_word_t gmem [mem_words];
	lane_word_t smem [shmem_words];
	logic       access;
	lane_vec_t  rd_data;

	// Misses leave both memories alone.
	assign access = in_i.valid && in_i.hit;

	// Lanes go in ascending order so the higher lane wins a shared address.
	always_ff @(posedge clk)
	begin
		if (preload_we_i)
			gmem[preload_addr_i[gaddr_bits-1:0]] <= preload_data_i;
		if (access && in_i.is_write)
		begin
			for (int l = 0; l < NUM_LANES; l++)
			begin
				if (in_i.mask[l])
				begin
					if (in_i.shared)
						smem[in_i.addr[l*aw +: saddr_bits]] <= in_i.data[l*dw +: dw];
					else
						gmem[in_i.addr[l*aw +: gaddr_bits]] <= in_i.data[l*dw +: dw];
				end
			end
		end
	end

	// Inactive lanes return zero.
	always_comb
	begin
		rd_data = '0;
		for (int l = 0; l < NUM_LANES; l++)
		begin
			if (access && in_i.is_read && in_i.mask[l])
			begin
				if (in_i.shared)
					rd_data[l*dw +: dw] = smem[in_i.addr[l*aw +: saddr_bits]];
				else
					rd_data[l*dw +: dw] = gmem[in_i.addr[l*aw +: gaddr_bits]];
			end
		end
	end

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			out_o.valid    <= 1'b0;
			out_o.is_read  <= 1'b0;
			out_o.is_write <= 1'b0;
		end
		else
		begin
			out_o.valid    <= in_i.valid;
			out_o.is_read  <= in_i.is_read;
			out_o.is_write <= in_i.is_write;
		end
	end

	always_ff @(posedge clk)
	begin
		out_o.shared   <= in_i.shared;
		out_o.warp     <= in_i.warp;
		out_o.scb      <= in_i.scb;
		out_o.mask     <= in_i.mask;
		out_o.reg_addr <= in_i.reg_addr;
		out_o.addr     <= in_i.addr;
		out_o.data     <= rd_data;
		out_o.hit      <= in_i.hit;
	end

	// Preload only happens while the pipeline is idle.
	preload_idle: assert property (@(posedge clk) disable iff (!rst)
		preload_we_i |-> !in_i.valid);

endmodule

/* rtl/mem_writeback.sv */
module mem_writeback
	import simt_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	mem_stage_if.dst   in_i,
	output logic       cdb_we_o,
	output reg_addr_t  cdb_reg_addr_o,
	output lane_mask_t cdb_mask_o,
	output lane_vec_t  cdb_data_o,
	output logic       pos_fb_valid_o,
	output warp_id_t   pos_fb_warp_o,
	output scb_id_t    pos_fb_scb_o,
	output lane_mask_t pos_fb_mask_o,
	output logic       neg_fb_valid_o,
	output warp_id_t   neg_fb_warp_o,
	output scb_id_t    neg_fb_scb_o
);

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			cdb_we_o       <= 1'b0;
			pos_fb_valid_o <= 1'b0;
			neg_fb_valid_o <= 1'b0;
		end
		else
		begin
			cdb_we_o       <= in_i.valid && in_i.hit && in_i.is_read;
			pos_fb_valid_o <= in_i.valid && in_i.hit && (in_i.is_read || in_i.is_write);
			// A miss goes back to the scoreboard for replay.
			neg_fb_valid_o <= in_i.valid && !in_i.hit;
		end
	end

	always_ff @(posedge clk)
	begin
		cdb_reg_addr_o <= in_i.reg_addr;
		cdb_mask_o     <= in_i.mask;
		cdb_data_o     <= in_i.data;
		pos_fb_warp_o  <= in_i.warp;
		pos_fb_scb_o   <= in_i.scb;
		pos_fb_mask_o  <= in_i.mask;
		neg_fb_warp_o  <= in_i.warp;
		neg_fb_scb_o   <= in_i.scb;
	end

	// Every valid slot ends in exactly one of the two feedback strobes.
	fb_exclusive: assert property (@(posedge clk) disable iff (!rst)
		in_i.valid |=> $onehot({pos_fb_valid_o, neg_fb_valid_o}));

endmodule

/* rtl/mem_unit.sv */
module mem_unit
	import simt_pkg::*;
	import mem_pkg::*;
#(
	parameter int mem_words   = 256,
	parameter int shmem_words = 256,
	parameter int cache_lines = 4
)
(
	input  logic       clk,
	input  logic       rst,
	input  logic       instr_valid_i,
	input  logic       mem_read_i,
	input  logic       mem_write_i,
	input  logic       shared_i,
	input  warp_id_t   warp_id_i,
	input  scb_id_t    scb_id_i,
	input  lane_mask_t lane_mask_i,
	input  lane_vec_t  rs_data_i,
	input  lane_vec_t  rt_data_i,
	input  offset_t    offset_i,
	input  reg_addr_t  reg_addr_i,
	input  logic       preload_we_i,
	input  word_addr_t preload_addr_i,
	input  lane_word_t preload_data_i,
	output logic       cdb_we_o,
	output reg_addr_t  cdb_reg_addr_o,
	output lane_mask_t cdb_mask_o,
	output lane_vec_t  cdb_data_o,
	output logic       pos_fb_valid_o,
	output warp_id_t   pos_fb_warp_o,
	output scb_id_t    pos_fb_scb_o,
	output lane_mask_t pos_fb_mask_o,
	output logic       neg_fb_valid_o,
	output warp_id_t   neg_fb_warp_o,
	output scb_id_t    neg_fb_scb_o
);

	mem_stage_if addr_tag ();
	mem_stage_if tag_acc ();
	mem_stage_if acc_wb ();

	mem_addr_gen u_addr_gen (
		.clk           (clk),
		.rst           (rst),
		.instr_valid_i (instr_valid_i),
		.mem_read_i    (mem_read_i),
		.mem_write_i   (mem_write_i),
		.shared_i      (shared_i),
		.warp_id_i     (warp_id_i),
		.scb_id_i      (scb_id_i),
		.lane_mask_i   (lane_mask_i),
		.rs_data_i     (rs_data_i),
		.rt_data_i     (rt_data_i),
		.offset_i      (offset_i),
		.reg_addr_i    (reg_addr_i),
		.out_o         (addr_tag.src)
	);

	mem_cache_tag #(
		.mem_words   (mem_words),
		.cache_lines (cache_lines)
	) u_cache_tag (
		.clk   (clk),
		.rst   (rst),
		.in_i  (addr_tag.dst),
		.out_o (tag_acc.src)
	);

	mem_data_access #(
		.mem_words   (mem_words),
		.shmem_words (shmem_words)
	) u_data_access (
		.clk            (clk),
		.rst            (rst),
		.preload_we_i   (preload_we_i),
		.preload_addr_i (preload_addr_i),
		.preload_data_i (preload_data_i),
		.in_i           (tag_acc.dst),
		.out_o          (acc_wb.src)
	);

	mem_writeback u_writeback (
		.clk            (clk),
		.rst            (rst),
		.in_i           (acc_wb.dst),
		.cdb_we_o       (cdb_we_o),
		.cdb_reg_addr_o (cdb_reg_addr_o),
		.cdb_mask_o     (cdb_mask_o),
		.cdb_data_o     (cdb_data_o),
		.pos_fb_valid_o (pos_fb_valid_o),
		.pos_fb_warp_o  (pos_fb_warp_o),
		.pos_fb_scb_o   (pos_fb_scb_o),
		.pos_fb_mask_o  (pos_fb_mask_o),
		.neg_fb_valid_o (neg_fb_valid_o),
		.neg_fb_warp_o  (neg_fb_warp_o),
		.neg_fb_scb_o   (neg_fb_scb_o)
	);

endmodule

/* tests/tb_clock.sv */
module tb_clock
(
	output logic clk_o,
	output logic rst_o
);

	// Reset is released just after the fourth rising edge.
	initial
	begin
		clk_o = 1'b0;
		rst_o = 1'b0;
		repeat (4) @(posedge clk_o);
		#1 rst_o = 1'b1;
	end

	always #20 clk_o = ~clk_o;

endmodule

/* tests/mem_unit_tb.sv */
module mem_unit_tb
	import simt_pkg::*;
	import mem_pkg::*;
();

	localparam int out_load  = 0;
	localparam int out_store = 1;
	localparam int out_miss  = 2;
	localparam int timeout   = 20;
	localparam int latency   = 5;
	localparam int mem_depth = 256;

	logic       clk;
	logic       rst;
	logic       instr_valid_i;
	logic       mem_read_i;
	logic       mem_write_i;
	logic       shared_i;
	warp_id_t   warp_id_i;
	scb_id_t    scb_id_i;
	lane_mask_t lane_mask_i;
	lane_vec_t  rs_data_i;
	lane_vec_t  rt_data_i;
	offset_t    offset_i;
	reg_addr_t  reg_addr_i;
	logic       preload_we_i;
	word_addr_t preload_addr_i;
	lane_word_t preload_data_i;
	logic       cdb_we_o;
	reg_addr_t  cdb_reg_addr_o;
	lane_mask_t cdb_mask_o;
	lane_vec_t  cdb_data_o;
	logic       pos_fb_valid_o;
	warp_id_t   pos_fb_warp_o;
	scb_id_t    pos_fb_scb_o;
	lane_mask_t pos_fb_mask_o;
	logic       neg_fb_valid_o;
	warp_id_t   neg_fb_warp_o;
	scb_id_t    neg_fb_scb_o;

	// Stimulus table, one column per queue.
	string      t_name [$];
	logic       t_write [$];
	logic       t_shared [$];
	warp_id_t   t_warp [$];
	scb_id_t    t_scb [$];
	lane_mask_t t_mask [$];
	reg_addr_t  t_reg [$];
	word_addr_t t_base [$];
	offset_t    t_off [$];
	lane_word_t t_data [$];
	int         t_exp [$];
	logic       t_b2b [$];

	// Outcomes still due, in issue order.
	int         due_entry [$];
	lane_vec_t  due_data [$];
	int         due_cycle [$];

	lane_word_t gmodel [mem_depth];
	lane_word_t smodel [mem_depth];
	logic [31:0] lcg_state;
	int         cycles;
	int         checks;
	int         errors;
	int         waited;

	tb_clock u_clock (
		.clk_o (clk),
		.rst_o (rst)
	);

	mem_unit uut (
		.clk            (clk),
		.rst            (rst),
		.instr_valid_i  (instr_valid_i),
		.mem_read_i     (mem_read_i),
		.mem_write_i    (mem_write_i),
		.shared_i       (shared_i),
		.warp_id_i      (warp_id_i),
		.scb_id_i       (scb_id_i),
		.lane_mask_i    (lane_mask_i),
		.rs_data_i      (rs_data_i),
		.rt_data_i      (rt_data_i),
		.offset_i       (offset_i),
		.reg_addr_i     (reg_addr_i),
		.preload_we_i   (preload_we_i),
		.preload_addr_i (preload_addr_i),
		.preload_data_i (preload_data_i),
		.cdb_we_o       (cdb_we_o),
		.cdb_reg_addr_o (cdb_reg_addr_o),
		.cdb_mask_o     (cdb_mask_o),
		.cdb_data_o     (cdb_data_o),
		.pos_fb_valid_o (pos_fb_valid_o),
		.pos_fb_warp_o  (pos_fb_warp_o),
		.pos_fb_scb_o   (pos_fb_scb_o),
		.pos_fb_mask_o  (pos_fb_mask_o),
		.neg_fb_valid_o (neg_fb_valid_o),
		.neg_fb_warp_o  (neg_fb_warp_o),
		.neg_fb_scb_o   (neg_fb_scb_o)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Word address of one lane, wrapped to the memory depth.
	function automatic int lane_addr(input int i, input int l);
		return (int'(t_base[i]) + l + int'(t_off[i])) & (mem_depth - 1);
	endfunction

	task automatic add_entry(input string name, input logic write, input logic shared,
		input warp_id_t warp, input scb_id_t scb, input lane_mask_t mask, input reg_addr_t rd,
		input word_addr_t base, input offset_t off, input lane_word_t data, input int outcome,
		input logic b2b);
		t_name.push_back(name);
		t_write.push_back(write);
		t_shared.push_back(shared);
		t_warp.push_back(warp);
		t_scb.push_back(scb);
		t_mask.push_back(mask);
		t_reg.push_back(rd);
		t_base.push_back(base);
		t_off.push_back(off);
		t_data.push_back(data);
		t_exp.push_back(outcome);
		t_b2b.push_back(b2b);
	endtask

	// Inputs change 1 time unit after each rising edge.
	task automatic next_cycle();
		@(posedge clk);
		#1;
		cycles++;
		instr_valid_i = 1'b0;
		preload_we_i  = 1'b0;
	endtask

	task automatic issue(input int i);
		lane_vec_t rs;
		lane_vec_t rt;
		lane_vec_t expect_data;
		int a;
		next_cycle();
		expect_data = '0;
		for (int l = 0; l < NUM_LANES; l++)
		begin
			a = lane_addr(i, l);
			rs[l*32 +: 32] = lane_word_t'(t_base[i]) + l;
			rt[l*32 +: 32] = t_data[i] + l;
			if (t_mask[i][l] && t_exp[i] == out_load)
				expect_data[l*32 +: 32] = t_shared[i] ? smodel[a] : gmodel[a];
			// Ascending lane order lets the higher lane win a shared address.
			if (t_mask[i][l] && t_exp[i] == out_store)
			begin
				if (t_shared[i])
					smodel[a] = t_data[i] + l;
				else
					gmodel[a] = t_data[i] + l;
			end
		end
		instr_valid_i = 1'b1;
		mem_read_i    = !t_write[i];
		mem_write_i   = t_write[i];
		shared_i      = t_shared[i];
		warp_id_i     = t_warp[i];
		scb_id_i      = t_scb[i];
		lane_mask_i   = t_mask[i];
		rs_data_i     = rs;
		rt_data_i     = rt;
		offset_i      = t_off[i];
		reg_addr_i    = t_reg[i];
		due_entry.push_back(i);
		due_data.push_back(expect_data);
		due_cycle.push_back(cycles + latency);
	endtask

	task automatic check_outcome();
		int i;
		int due;
		lane_vec_t expect_data;
		logic [2:0] expect_strobes;
		i = due_entry.pop_front();
		due = due_cycle.pop_front();
		expect_data = due_data.pop_front();
		expect_strobes = (t_exp[i] == out_load) ? 3'b110 :
			(t_exp[i] == out_store) ? 3'b010 : 3'b001;
		next_cycle();
		waited = 0;
		while (!(cdb_we_o || pos_fb_valid_o || neg_fb_valid_o) && waited < timeout)
		begin
			next_cycle();
			waited++;
		end
		checks++;
		if (!(cdb_we_o || pos_fb_valid_o || neg_fb_valid_o))
		begin
			$display("Timed out waiting for the outcome of %s", t_name[i]);
			errors++;
			return;
		end
		if (cycles != due)
		begin
			$display("ERROR %s latency expected %0d actual %0d", t_name[i],
				latency, cycles - due + latency);
			errors++;
		end
		if ({cdb_we_o, pos_fb_valid_o, neg_fb_valid_o} != expect_strobes)
		begin
			$display("ERROR %s strobes expected %b actual %b", t_name[i], expect_strobes,
				{cdb_we_o, pos_fb_valid_o, neg_fb_valid_o});
			errors++;
		end
		else if (t_exp[i] == out_miss)
		begin
			if (neg_fb_warp_o != t_warp[i] || neg_fb_scb_o != t_scb[i])
			begin
				$display("ERROR %s neg warp/scb expected %0d/%0d actual %0d/%0d", t_name[i],
					t_warp[i], t_scb[i], neg_fb_warp_o, neg_fb_scb_o);
				errors++;
			end
		end
		else
		begin
			if (pos_fb_warp_o != t_warp[i] || pos_fb_scb_o != t_scb[i])
			begin
				$display("ERROR %s pos warp/scb expected %0d/%0d actual %0d/%0d", t_name[i],
					t_warp[i], t_scb[i], pos_fb_warp_o, pos_fb_scb_o);
				errors++;
			end
			if (pos_fb_mask_o != t_mask[i])
			begin
				$display("ERROR %s pos mask expected %h actual %h", t_name[i], t_mask[i],
					pos_fb_mask_o);
				errors++;
			end
			if (t_exp[i] == out_load && (cdb_reg_addr_o != t_reg[i] || cdb_mask_o != t_mask[i]))
			begin
				$display("ERROR %s cdb reg/mask expected %0d/%h actual %0d/%h", t_name[i],
					t_reg[i], t_mask[i], cdb_reg_addr_o, cdb_mask_o);
				errors++;
			end
			if (t_exp[i] == out_load && cdb_data_o !== expect_data)
			begin
				$display("ERROR %s data expected %h actual %h", t_name[i], expect_data,
					cdb_data_o);
				errors++;
			end
		end
	endtask

	initial
	begin
		instr_valid_i  = 1'b0;
		mem_read_i     = 1'b0;
		mem_write_i    = 1'b0;
		shared_i       = 1'b0;
		warp_id_i      = '0;
		scb_id_i       = '0;
		lane_mask_i    = '0;
		rs_data_i      = '0;
		rt_data_i      = '0;
		offset_i       = '0;
		reg_addr_i     = '0;
		preload_we_i   = 1'b0;
		preload_addr_i = '0;
		preload_data_i = '0;
		cycles = 0;
		checks = 0;
		errors = 0;
		lcg_state = 32'hfa7a;

		// Global lines 2, 0 and 4 share tag entries 2 and 0; line 3 is reached by offset.
		add_entry("ld_cold", 1'b0, 1'b0, 3'd1, 2'd0, 8'hff, 5'd3, 16'h0010, 16'sd0,
			32'h0, out_miss, 1'b0);
		add_entry("ld_replay", 1'b0, 1'b0, 3'd1, 2'd0, 8'hff, 5'd3, 16'h0010, 16'sd0,
			32'h0, out_load, 1'b0);
		add_entry("st_masked", 1'b1, 1'b0, 3'd2, 2'd1, 8'h5a, 5'd0, 16'h0010, 16'sd0,
			32'ha000_0000, out_store, 1'b0);
		add_entry("ld_merged", 1'b0, 1'b0, 3'd2, 2'd2, 8'hff, 5'd4, 16'h0010, 16'sd0,
			32'h0, out_load, 1'b0);
		add_entry("ld_partial", 1'b0, 1'b0, 3'd3, 2'd3, 8'h0f, 5'd5, 16'h0010, 16'sd0,
			32'h0, out_load, 1'b0);
		add_entry("sh_store", 1'b1, 1'b1, 3'd4, 2'd0, 8'hff, 5'd0, 16'h0010, 16'sd0,
			32'hb000_0000, out_store, 1'b0);
		add_entry("sh_load", 1'b0, 1'b1, 3'd4, 2'd1, 8'hff, 5'd6, 16'h0010, 16'sd0,
			32'h0, out_load, 1'b0);
		add_entry("gl_after_sh", 1'b0, 1'b0, 3'd5, 2'd2, 8'hff, 5'd7, 16'h0010, 16'sd0,
			32'h0, out_load, 1'b0);
		add_entry("ld_line0", 1'b0, 1'b0, 3'd5, 2'd3, 8'hff, 5'd8, 16'h0000, 16'sd0,
			32'h0, out_miss, 1'b0);
		add_entry("ld_line0_re", 1'b0, 1'b0, 3'd5, 2'd3, 8'hff, 5'd8, 16'h0000, 16'sd0,
			32'h0, out_load, 1'b0);
		add_entry("ld_line4", 1'b0, 1'b0, 3'd6, 2'd0, 8'hff, 5'd9, 16'h0020, 16'sd0,
			32'h0, out_miss, 1'b0);
		add_entry("ld_line4_re", 1'b0, 1'b0, 3'd6, 2'd0, 8'hff, 5'd9, 16'h0020, 16'sd0,
			32'h0, out_load, 1'b0);
		add_entry("ld_line0_evicted", 1'b0, 1'b0, 3'd5, 2'd1, 8'hff, 5'd8, 16'h0000, 16'sd0,
			32'h0, out_miss, 1'b0);
		add_entry("ld_neg_off", 1'b0, 1'b0, 3'd7, 2'd2, 8'hff, 5'd10, 16'h0028, -16'sd16,
			32'h0, out_miss, 1'b0);
		add_entry("ld_neg_off_re", 1'b0, 1'b0, 3'd7, 2'd2, 8'hff, 5'd10, 16'h0028, -16'sd16,
			32'h0, out_load, 1'b0);
		add_entry("st_b2b", 1'b1, 1'b0, 3'd0, 2'd0, 8'hff, 5'd0, 16'h0018, 16'sd0,
			32'hc000_0000, out_store, 1'b1);
		add_entry("ld_b2b", 1'b0, 1'b0, 3'd0, 2'd1, 8'hff, 5'd11, 16'h0018, 16'sd0,
			32'h0, out_load, 1'b1);
		add_entry("sh_ld_b2b", 1'b0, 1'b1, 3'd1, 2'd2, 8'h3c, 5'd12, 16'h0030, 16'sd0,
			32'h0, out_load, 1'b0);

		for (int a = 0; a < mem_depth; a++)
			smodel[a] = '0;

		// Preload starts under reset and runs on past it while the pipeline is idle.
		for (int a = 0; a < mem_depth; a++)
		begin
			next_cycle();
			lcg_state = lcg_next(lcg_state);
			gmodel[a] = lcg_state;
			preload_we_i   = 1'b1;
			preload_addr_i = word_addr_t'(a);
			preload_data_i = lcg_state;
		end

		waited = 0;
		while (!rst && waited < timeout)
		begin
			next_cycle();
			waited++;
		end
		if (!rst)
		begin
			$display("Reset was never released");
			errors++;
		end

		for (int i = 0; i < t_name.size(); i++)
		begin
			issue(i);
			if (!t_b2b[i])
			begin
				while (due_entry.size() > 0)
					check_outcome();
			end
		end

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* verilog.f */
rtl/simt_pkg.sv
rtl/mem_pkg.sv
rtl/mem_stage_if.sv
rtl/mem_addr_gen.sv
rtl/mem_cache_tag.sv
rtl/mem_data_access.sv
rtl/mem_writeback.sv
rtl/mem_unit.sv
tests/tb_clock.sv
tests/mem_unit_tb.sv

/* Bender.yml */
package:
  name: simt_mem_unit

sources:
  - rtl/simt_pkg.sv
  - rtl/mem_pkg.sv
  - rtl/mem_stage_if.sv
  - rtl/mem_addr_gen.sv
  - rtl/mem_cache_tag.sv
  - rtl/mem_data_access.sv
  - rtl/mem_writeback.sv
  - rtl/mem_unit.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/mem_unit_tb.sv
